// File: filelist.f
+incdir+include
hdl/seq_pkg.sv
hdl/seq_issue_if.sv
hdl/delay_line.sv
hdl/branch_unit.sv
hdl/thread_pc_store.sv
hdl/io_issue_stage.sv
hdl/pc_controller.sv
hdl/barrel_sequencer_top.sv
tests/barrel_sequencer_properties.sv
tests/barrel_sequencer_tb.sv

// File: hdl/barrel_sequencer_top.sv
`timescale 1ns/1ns
`default_nettype none

`include "seq_consts.svh"

module barrel_sequencer_top (
    input  wire                          clock,
    input  wire                          rst,

    // Instruction result for the thread due this cycle
    input  var   seq_pkg::op_t           op,
    input  wire  [`SEQ_A_WIDTH-1:0]      a_value,
    input  wire  [`SEQ_PC_WIDTH-1:0]     d_target,

    // Next fetch address
    output logic [`SEQ_PC_WIDTH-1:0]     pc,
    output logic [`SEQ_THREAD_WIDTH-1:0] pc_thread,

    // External device handshake
    output logic                         io_req,
    output logic [`SEQ_THREAD_WIDTH-1:0] io_thread,
    input  wire                          io_ack
);

    seq_issue_if issue_bus ();

    // ******************************
    // I/O stage
    // ******************************

    io_issue_stage io_issue_stage_i (
        .clock     (clock),
        .rst       (rst),
        .op        (op),
        .a_value   (a_value),
        .d_target  (d_target),
        .io_ack    (io_ack),
        .io_req    (io_req),
        .io_thread (io_thread),
        .issue     (issue_bus.issue)
    );

    // ******************************
    // PC controller
    // ******************************

    pc_controller pc_controller_i (
        .clock     (clock),
        .rst       (rst),
        .issue     (issue_bus.ctrl),
        .pc        (pc),
        .pc_thread (pc_thread)
    );

endmodule

`default_nettype wire

// File: hdl/branch_unit.sv
`timescale 1ns/1ns
`default_nettype none

`include "seq_consts.svh"

module branch_unit (
    input  wire                      clock,
    input  wire                      rst,
    input  wire [`SEQ_A_WIDTH-1:0]   a_value,
    input  var  seq_pkg::op_t        op,
    output logic                     jump
);

    logic a_zero;
    logic a_positive;
    logic take;

    // ******************************
    // Stage 1: accumulator flags
    // ******************************

    always_ff @(posedge clock) begin
        a_zero     <= (a_value == '0);
        a_positive <= ~a_value[`SEQ_A_WIDTH-1];
    end

    // ******************************
    // Stage 2: jump decision
    // ******************************

    // Op arrives one cycle late so it lines up with the flags
    always_comb begin
        case (op)
            seq_pkg::OP_JMP: take = 1'b1;
            seq_pkg::OP_JZE: take = a_zero;
            seq_pkg::OP_JNZ: take = ~a_zero;
            seq_pkg::OP_JPO: take = a_positive;
            seq_pkg::OP_JNE: take = ~a_positive;
            default:         take = 1'b0;
        endcase
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            jump <= 1'b0;
        end else begin
            jump <= take;
        end
    end

endmodule

`default_nettype wire

// File: hdl/delay_line.sv
`timescale 1ns/1ns
`default_nettype none

module delay_line #(
    parameter int               DEPTH       = 1,
    parameter int               WIDTH       = 1,
    parameter logic [WIDTH-1:0] RESET_VALUE = '0
) (
    input  wire              clock,
    input  wire              rst,
    input  wire  [WIDTH-1:0] in,
    output logic [WIDTH-1:0] out
);

    logic [WIDTH-1:0] stages [DEPTH];

    always_ff @(posedge clock) begin
        if (rst) begin
            for (int i = 0; i < DEPTH; i++) begin
                stages[i] <= RESET_VALUE;
            end
        end else begin
            stages[0] <= in;
            for (int i = 1; i < DEPTH; i++) begin
                stages[i] <= stages[i-1];
            end
        end
    end

    assign out = stages[DEPTH-1];

endmodule

`default_nettype wire

// File: hdl/io_issue_stage.sv
`timescale 1ns/1ns
`default_nettype none

`include "seq_consts.svh"

module io_issue_stage (
    input  wire                          clock,
    input  wire                          rst,
    input  var   seq_pkg::op_t           op,
    input  wire  [`SEQ_A_WIDTH-1:0]      a_value,
    input  wire  [`SEQ_PC_WIDTH-1:0]     d_target,
    input  wire                          io_ack,
    output logic                         io_req,
    output logic [`SEQ_THREAD_WIDTH-1:0] io_thread,
    seq_issue_if.issue                   issue
);

    seq_pkg::io_state_t             state;
    logic [`SEQ_THREAD_WIDTH-1:0]   owner;
    logic                           is_iop;
    logic                           owner_turn;
    logic                           io_ready;

    // Result fields go straight on to the controller
    assign issue.op       = op;
    assign issue.a_value  = a_value;
    assign issue.d_target = d_target;

    assign is_iop     = (op == seq_pkg::OP_IOP);
    assign owner_turn = (issue.slot == owner);

    // ******************************
    // Ready flag
    // ******************************

    // Only the owning thread may pass, and only once the device is done
    always_comb begin
        io_ready = 1'b1;
        if (is_iop) begin
            io_ready = (state == seq_pkg::IO_DONE) && owner_turn;
        end
    end

    assign issue.io_ready = io_ready;

    // ******************************
    // Handshake FSM
    // ******************************

    always_ff @(posedge clock) begin
        if (rst) begin
            state  <= seq_pkg::IO_IDLE;
            io_req <= 1'b0;
            owner  <= '0;
        end else begin
            case (state)
                seq_pkg::IO_IDLE: begin
                    // Any thread may claim the free channel
                    if (is_iop) begin
                        owner  <= issue.slot;
                        io_req <= 1'b1;
                        state  <= seq_pkg::IO_REQ;
                    end
                end
                seq_pkg::IO_REQ: begin
                    if (io_ack) begin
                        io_req <= 1'b0;
                        state  <= seq_pkg::IO_RELEASE;
                    end
                end
                seq_pkg::IO_RELEASE: begin
                    // Device has finished once ack drops
                    if (!io_ack) begin
                        state <= seq_pkg::IO_DONE;
                    end
                end
                seq_pkg::IO_DONE: begin
                    if (is_iop && owner_turn) begin
                        state <= seq_pkg::IO_IDLE;
                    end
                end
                default: state <= seq_pkg::IO_IDLE;
            endcase
        end
    end

    assign io_thread = owner;

endmodule

`default_nettype wire

// File: hdl/pc_controller.sv
`timescale 1ns/1ns
`default_nettype none

`include "seq_consts.svh"

module pc_controller (
    input  wire                          clock,
    input  wire                          rst,
    seq_issue_if.ctrl                    issue,
    output logic [`SEQ_PC_WIDTH-1:0]     pc,
    output logic [`SEQ_THREAD_WIDTH-1:0] pc_thread
);

    logic [`SEQ_THREAD_WIDTH-1:0]   thread;
    logic [`SEQ_THREAD_WIDTH-1:0]   next_thread;

    logic [$bits(seq_pkg::op_t)-1:0] op_d1;
    logic [`SEQ_PC_WIDTH-1:0]       target_d2;
    logic                           ready_d2;
    logic                           jump;

    logic [`SEQ_PC_WIDTH-1:0]       stored_pc;
    logic [`SEQ_PC_WIDTH-1:0]       pc_raw;
    logic [`SEQ_PC_WIDTH-1:0]       next_pc;

    // ******************************
    // Thread counter
    // ******************************

    always_comb begin
        if (thread == `SEQ_THREAD_WIDTH'(`SEQ_THREAD_COUNT - 1)) begin
            next_thread = '0;
        end else begin
            next_thread = thread + `SEQ_THREAD_WIDTH'(1);
        end
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            thread <= '0;
        end else begin
            thread <= next_thread;
        end
    end

    assign pc_thread = thread;

    // Results arriving now belong to the thread emitted two cycles from now
    assign issue.slot = thread + `SEQ_THREAD_WIDTH'(2);

    // ******************************
    // Pipeline alignment
    // ******************************

    delay_line #(
        .DEPTH       (1),
        .WIDTH       ($bits(seq_pkg::op_t)),
        .RESET_VALUE (seq_pkg::OP_NOP)
    ) op_delay (
        .clock (clock),
        .rst   (rst),
        .in    (issue.op),
        .out   (op_d1)
    );

    delay_line #(
        .DEPTH       (2),
        .WIDTH       (`SEQ_PC_WIDTH),
        .RESET_VALUE ('0)
    ) target_delay (
        .clock (clock),
        .rst   (rst),
        .in    (issue.d_target),
        .out   (target_d2)
    );

    // Resets to ready so the first results act as plain NOPs
    delay_line #(
        .DEPTH       (2),
        .WIDTH       (1),
        .RESET_VALUE (1'b1)
    ) ready_delay (
        .clock (clock),
        .rst   (rst),
        .in    (issue.io_ready),
        .out   (ready_d2)
    );

    branch_unit branch (
        .clock   (clock),
        .rst     (rst),
        .a_value (issue.a_value),
        .op      (seq_pkg::op_t'(op_d1)),
        .jump    (jump)
    );

    // ******************************
    // Next PC
    // ******************************

    thread_pc_store pc_store (
        .clock        (clock),
        .rst          (rst),
        .write_thread (thread),
        .write_pc     (next_pc),
        .read_thread  (next_thread),
        .read_pc      (stored_pc)
    );

    assign pc_raw = jump ? target_d2 : stored_pc;

    // A waiting thread steps back onto its I/O instruction
    assign pc      = ready_d2 ? pc_raw : pc_raw - `SEQ_PC_WIDTH'(1);
    assign next_pc = pc_raw + `SEQ_PC_WIDTH'(ready_d2);

endmodule

`default_nettype wire

// File: hdl/seq_issue_if.sv
`timescale 1ns/1ns
`default_nettype none

`include "seq_consts.svh"

interface seq_issue_if;

    // Instruction result for the thread in slot
    seq_pkg::op_t                   op;
    logic [`SEQ_A_WIDTH-1:0]        a_value;
    logic [`SEQ_PC_WIDTH-1:0]       d_target;

    // Low while the thread must re-fetch its I/O instruction
    logic                           io_ready;

    // Thread that owns the result presented this cycle
    logic [`SEQ_THREAD_WIDTH-1:0]   slot;

    modport issue (
        output op, a_value, d_target, io_ready,
        input  slot
    );

    modport ctrl (
        input  op, a_value, d_target, io_ready,
        output slot
    );

endinterface

`default_nettype wire

// File: hdl/seq_pkg.sv
`default_nettype none

package seq_pkg;

    // ******************************
    // Opcodes seen by the controller
    // ******************************

    typedef enum logic [2:0] {
        OP_NOP = 3'd0,
        // Unconditional jump
        OP_JMP = 3'd1,
        // Accumulator zero / nonzero
        OP_JZE = 3'd2,
        OP_JNZ = 3'd3,
        // Sign bit clear / set
        OP_JPO = 3'd4,
        OP_JNE = 3'd5,
        // Blocks the thread until the device handshake is done
        OP_IOP = 3'd6
    } op_t;

    // Four-phase handshake progress of the single I/O channel
    typedef enum logic [1:0] {
        IO_IDLE    = 2'd0,
        IO_REQ     = 2'd1,
        IO_RELEASE = 2'd2,
        IO_DONE    = 2'd3
    } io_state_t;

endpackage

`default_nettype wire

// File: hdl/thread_pc_store.sv
`timescale 1ns/1ns
`default_nettype none

`include "seq_consts.svh"

module thread_pc_store (
    input  wire                          clock,
    input  wire                          rst,
    input  wire  [`SEQ_THREAD_WIDTH-1:0] write_thread,
    input  wire  [`SEQ_PC_WIDTH-1:0]     write_pc,
    input  wire  [`SEQ_THREAD_WIDTH-1:0] read_thread,
    output logic [`SEQ_PC_WIDTH-1:0]     read_pc
);

    // Next fetch address of each thread
    logic [`SEQ_PC_WIDTH-1:0] entries [`SEQ_THREAD_COUNT];

    // ******************************
    // Write current, read next
    // ******************************

    // Read and write threads always differ by one, so a read never
    // sees the entry being written in the same cycle
    always_ff @(posedge clock) begin
        if (rst) begin
            for (int k = 0; k < `SEQ_THREAD_COUNT; k++) begin
                entries[k] <= `SEQ_PC_WIDTH'(k * `SEQ_THREAD_STRIDE);
            end
            // Thread 0 start address
            read_pc <= '0;
        end else begin
            entries[write_thread] <= write_pc;
            read_pc               <= entries[read_thread];
        end
    end

endmodule

`default_nettype wire

// File: include/seq_consts.svh
`ifndef SEQ_CONSTS_SVH
`define SEQ_CONSTS_SVH

// ******************************
// Datapath widths
// ******************************

`define SEQ_PC_WIDTH        10
`define SEQ_A_WIDTH         16

// ******************************
// Thread round
// ******************************

// Round length equals the pipeline depth from result to next fetch
`define SEQ_THREAD_COUNT    4
`define SEQ_THREAD_WIDTH    2

// Thread k starts fetching at k * stride
`define SEQ_THREAD_STRIDE   64

`endif

// File: tests/barrel_sequencer_properties.sv
`timescale 1ns/1ns
`default_nettype none

`include "seq_consts.svh"

module barrel_sequencer_properties #(
    parameter bit HANDSHAKE = 1'b1
) (
    input wire                         clock,
    input wire                         rst,
    input wire                         req,
    input wire                         ack,
    input wire [`SEQ_THREAD_WIDTH-1:0] thread
);

    int failures = 0;

    generate
        if (HANDSHAKE) begin : handshake_checks
            // ******************************
            // Four-phase req/ack ordering
            // ******************************
            req_low_after_reset: assert property (@(posedge clock) rst |=> !req)
                else begin
                    failures++;
                    $error("io_req not low after reset");
                end
            // Request only drops once the device has acknowledged
            req_waits_for_ack: assert property (@(posedge clock) disable iff (rst)
                $fell(req) |-> $past(ack))
                else begin
                    failures++;
                    $error("io_req fell before io_ack was high");
                end
            req_after_ack_low: assert property (@(posedge clock) disable iff (rst)
                $rose(req) |-> !$past(ack))
                else begin
                    failures++;
                    $error("io_req rose while io_ack was still high");
                end
        end else begin : rotation_checks
            thread_starts_at_zero: assert property (@(posedge clock) rst |=> thread == '0)
                else begin
                    failures++;
                    $error("pc_thread not 0 after reset");
                end
            // One step per cycle, wrapping after the last thread
            thread_steps: assert property (@(posedge clock) disable iff (rst)
                !$past(rst) |-> thread == $past(thread) + 2'd1)
                else begin
                    failures++;
                    $error("pc_thread did not advance by one");
                end
        end
    endgenerate

endmodule

bind io_issue_stage barrel_sequencer_properties #(.HANDSHAKE(1'b1)) handshake_props (
    .clock  (clock),
    .rst    (rst),
    .req    (io_req),
    .ack    (io_ack),
    .thread (io_thread)
);

bind pc_controller barrel_sequencer_properties #(.HANDSHAKE(1'b0)) rotation_props (
    .clock  (clock),
    .rst    (rst),
    .req    (1'b0),
    .ack    (1'b0),
    .thread (pc_thread)
);

`default_nettype wire

// File: tests/barrel_sequencer_tb.sv
`timescale 1ns/1ns
`default_nettype none

`include "seq_consts.svh"

module barrel_sequencer_tb;

    logic                           clock;
    logic                           rst;
    seq_pkg::op_t                   op;
    logic [`SEQ_A_WIDTH-1:0]        a_value;
    logic [`SEQ_PC_WIDTH-1:0]       d_target;
    logic                           io_ack;
    logic [`SEQ_PC_WIDTH-1:0]       pc;
    logic [`SEQ_THREAD_WIDTH-1:0]   pc_thread;
    logic                           io_req;
    logic [`SEQ_THREAD_WIDTH-1:0]   io_thread;

    // Stimulus table with one row per cycle
    // The taken column holds the expected branch outcome
    seq_pkg::op_t                   row_op [$];
    logic [`SEQ_A_WIDTH-1:0]        row_a [$];
    logic [`SEQ_PC_WIDTH-1:0]       row_target [$];
    int                             row_delay [$];
    bit                             row_taken [$];

    // Reference model state
    logic [`SEQ_PC_WIDTH-1:0]       model_s [`SEQ_THREAD_COUNT];
    bit                             model_ready [$];
    seq_pkg::io_state_t             model_state;
    logic                           model_req;
    logic [`SEQ_THREAD_WIDTH-1:0]   model_owner;

    logic [31:0]                    lcg_state;
    int                             pending_delay;
    int                             error_count;
    int                             check_count;
    int                             property_failures;
    int                             cycle_count;
    int                             timeout_limit;

    barrel_sequencer_top barrel_sequencer_top_i (
        .clock     (clock),
        .rst       (rst),
        .op        (op),
        .a_value   (a_value),
        .d_target  (d_target),
        .pc        (pc),
        .pc_thread (pc_thread),
        .io_req    (io_req),
        .io_thread (io_thread),
        .io_ack    (io_ack)
    );

    initial begin
        clock = 1'b0;
        forever begin
            #10 clock = ~clock;
        end
    end

    function automatic logic [15:0] next_random();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state[30:15];
    endfunction

    task automatic add_row(input seq_pkg::op_t r_op, input logic [15:0] a,
                           input logic [9:0] target, input int delay, input bit taken);
        row_op.push_back(r_op);
        row_a.push_back(a);
        row_target.push_back(target);
        row_delay.push_back(delay);
        row_taken.push_back(taken);
    endtask

    task automatic add_filler(input seq_pkg::op_t r_op, input int count, input int delay);
        for (int i = 0; i < count; i++) begin
            add_row(r_op, next_random(), `SEQ_PC_WIDTH'(next_random()), delay, 1'b0);
        end
    endtask

    // ******************************
    // Stimulus table
    // ******************************

    // Row c is the result for thread (c + 2) mod 4
    task automatic build_table();
        add_filler(seq_pkg::OP_NOP, 8, 0);
        add_row(seq_pkg::OP_JMP, 16'h4321, 10'h155, 0, 1'b1);
        add_row(seq_pkg::OP_JZE, 16'h0000, 10'h0a0, 0, 1'b1);
        add_row(seq_pkg::OP_JZE, 16'h0005, 10'h0a4, 0, 1'b0);
        add_row(seq_pkg::OP_JNZ, 16'h0000, 10'h0b0, 0, 1'b0);
        // Thread 2 falls through here to the jump target plus one
        add_row(seq_pkg::OP_JNE, 16'h0000, 10'h3d4, 0, 1'b0);
        add_row(seq_pkg::OP_JPO, 16'h7fff, 10'h2c0, 0, 1'b1);
        add_row(seq_pkg::OP_JPO, 16'h8000, 10'h2c4, 0, 1'b0);
        add_row(seq_pkg::OP_JNE, 16'h8000, 10'h3d0, 0, 1'b1);
        add_row(seq_pkg::OP_JNZ, 16'h1234, 10'h0b4, 0, 1'b1);
        add_row(seq_pkg::OP_JNZ, 16'hffff, 10'h3e0, 0, 1'b1);
        add_filler(seq_pkg::OP_NOP, 6, 0);
        // Thread 2 takes the channel at row 24, thread 3 queues behind it
        add_filler(seq_pkg::OP_IOP, 1, 2);
        add_filler(seq_pkg::OP_IOP, 1, 0);
        add_filler(seq_pkg::OP_NOP, 2, 0);
        add_filler(seq_pkg::OP_IOP, 2, 0);
        add_filler(seq_pkg::OP_NOP, 2, 0);
        add_filler(seq_pkg::OP_IOP, 2, 0);
        add_filler(seq_pkg::OP_NOP, 3, 0);
        add_filler(seq_pkg::OP_IOP, 1, 0);
        add_filler(seq_pkg::OP_NOP, 3, 0);
        add_filler(seq_pkg::OP_IOP, 1, 0);
        add_filler(seq_pkg::OP_NOP, 8, 0);
    endtask

    task automatic report_mismatch(input string name, input int c,
                                   input logic [31:0] got, input logic [31:0] expected);
        error_count++;
        $display("CHECK FAILED cycle %0d: %s = 0x%0h, expected 0x%0h", c, name, got, expected);
    endtask

    // ******************************
    // Reference model and checks
    // ******************************

    task automatic check_cycle(input int c);
        int                           k;
        logic [`SEQ_THREAD_WIDTH-1:0] slot;
        logic [`SEQ_PC_WIDTH-1:0]     x;
        logic [`SEQ_PC_WIDTH-1:0]     exp_pc;
        bit                           is_iop;
        bit                           ready_r;
        k = c % `SEQ_THREAD_COUNT;
        slot = `SEQ_THREAD_WIDTH'(c + 2);
        is_iop = (row_op[c] == seq_pkg::OP_IOP);
        model_ready.push_back(!is_iop ||
                              (model_state == seq_pkg::IO_DONE && slot == model_owner));
        // First two cycles after reset behave as NOP results
        x = model_s[k];
        ready_r = 1'b1;
        if (c >= 2) begin
            ready_r = model_ready[c-2];
            if (row_taken[c-2]) begin
                x = row_target[c-2];
            end
        end
        exp_pc = ready_r ? x : x - 1'b1;
        model_s[k] = x + (ready_r ? 1 : 0);
        check_count += 4;
        assert (pc_thread === `SEQ_THREAD_WIDTH'(k))
            else report_mismatch("pc_thread", c, pc_thread, k);
        assert (pc === exp_pc)
            else report_mismatch("pc", c, pc, exp_pc);
        assert (io_req === model_req)
            else report_mismatch("io_req", c, io_req, model_req);
        assert (io_thread === model_owner)
            else report_mismatch("io_thread", c, io_thread, model_owner);
        case (model_state)
            seq_pkg::IO_IDLE: begin
                if (is_iop) begin
                    model_owner = slot;
                    model_req = 1'b1;
                    model_state = seq_pkg::IO_REQ;
                    pending_delay = row_delay[c];
                end
            end
            seq_pkg::IO_REQ: begin
                if (io_ack) begin
                    model_req = 1'b0;
                    model_state = seq_pkg::IO_RELEASE;
                end
            end
            seq_pkg::IO_RELEASE: begin
                if (!io_ack) begin
                    model_state = seq_pkg::IO_DONE;
                end
            end
            default: begin
                if (is_iop && slot == model_owner) begin
                    model_state = seq_pkg::IO_IDLE;
                end
            end
        endcase
    endtask

    // Device side of the handshake
    initial begin
        io_ack = 1'b0;
        forever begin
            @(negedge clock);
            if (io_req && !io_ack) begin
                repeat (pending_delay) @(negedge clock);
                @(posedge clock);
                io_ack <= 1'b1;
                do begin
                    @(negedge clock);
                end while (io_req);
                @(posedge clock);
                io_ack <= 1'b0;
            end
        end
    end

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
    end

    initial begin
        wait (timeout_limit > 0 && cycle_count >= timeout_limit);
        $display("Timeout: run still going after %0d cycles", cycle_count);
        $display("TEST FAIL");
        $finish;
    end

    initial begin
        rst = 1'b1;
        op = seq_pkg::OP_NOP;
        a_value = '0;
        d_target = '0;
        error_count = 0;
        check_count = 0;
        cycle_count = 0;
        timeout_limit = 0;
        pending_delay = 0;
        lcg_state = 32'd29;
        for (int k = 0; k < `SEQ_THREAD_COUNT; k++) begin
            model_s[k] = `SEQ_PC_WIDTH'(k * `SEQ_THREAD_STRIDE);
        end
        model_state = seq_pkg::IO_IDLE;
        model_req = 1'b0;
        model_owner = '0;
        build_table();
        timeout_limit = row_op.size() * 4 + 200;
        repeat (4) @(posedge clock);
        rst <= 1'b0;
        for (int c = 0; c < row_op.size(); c++) begin
            if (c > 0) begin
                @(posedge clock);
            end
            op <= row_op[c];
            a_value <= row_a[c];
            d_target <= row_target[c];
            @(negedge clock);
            check_cycle(c);
        end
        assert (model_state == seq_pkg::IO_IDLE) else begin
            error_count++;
            $display("I/O requests were still pending when the table ran out");
        end
        property_failures = barrel_sequencer_top_i.io_issue_stage_i.handshake_props.failures
                          + barrel_sequencer_top_i.pc_controller_i.rotation_props.failures;
        $display("Checks: %0d, errors: %0d, property failures: %0d",
                 check_count, error_count, property_failures);
        if (error_count == 0 && property_failures == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
